//--- include/cheat_config.svh
// Cheat engine configuration
`ifndef CHEAT_CONFIG_SVH
`define CHEAT_CONFIG_SVH

// SDRAM bank address width
`define CHEAT_AW 22

// Instruction RAM address width, 256 words
`define CHEAT_IAW 8

// Frames a program may run without reaching END
`define CHEAT_WDOG_FRAMES 8

`endif

//--- verilog/cheat_pkg.sv
// Cheat engine types
`include "cheat_config.svh"

package cheat_pkg;

    typedef logic [`CHEAT_IAW-1:0] iaddr_t;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDI = 4'd1,
        WR  = 4'd2,
        RD  = 4'd3,
        JMP = 4'd4,
        END = 4'd5
    } cheat_op_e;

    typedef enum logic [1:0] {
        ALWAYS = 2'd0,
        EQ     = 2'd1,
        NE     = 2'd2
    } cheat_cond_e;

    // Immediate load view
    typedef struct packed {
        cheat_op_e  op;
        logic [2:0] rsv;
        logic [2:0] rd;
        logic [7:0] imm;
    } cheat_imm_t;

    // Branch view, only the low CHEAT_IAW target bits reach the pc
    typedef struct packed {
        cheat_op_e   op;
        cheat_cond_e cond;
        logic [11:0] target;
    } cheat_jmp_t;

    typedef union packed {
        cheat_imm_t imm;
        cheat_jmp_t jmp;
    } cheat_instr_u;

    // Byte register map
    localparam logic [2:0] ADDR0    = 3'd0;
    localparam logic [2:0] ADDR1    = 3'd1;
    localparam logic [2:0] ADDR2    = 3'd2;
    localparam logic [2:0] DATA_LO  = 3'd3;
    localparam logic [2:0] DATA_HI  = 3'd4;
    localparam logic [2:0] MASK     = 3'd5;
    localparam logic [2:0] RDATA_LO = 3'd6;
    localparam logic [2:0] RDATA_HI = 3'd7;

endpackage

//--- verilog/sdram_if.sv
// SDRAM requester bus
`include "cheat_config.svh"

interface sdram_if;

    // Request side, held until rdy
    logic [`CHEAT_AW-1:0] addr;
    logic                 rd;
    logic                 wr;
    logic [15:0]          din;
    logic [1:0]           din_m;

    // Response side
    logic                 dst;
    logic                 rdy;
    logic [15:0]          dout;

    modport requester (
        output addr, rd, wr, din, din_m,
        input  dst, rdy, dout
    );

    modport arbiter (
        input  addr, rd, wr, din, din_m,
        output dst, rdy, dout
    );

endinterface

//--- verilog/cheat_loader.sv
// Program byte stream packer
`include "cheat_config.svh"

module cheat_loader (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prog_en,
    input  logic                   prog_wr,
    input  logic [7:0]             prog_data,
    output logic                   we,
    output logic [`CHEAT_IAW-1:0]  waddr,
    output cheat_pkg::cheat_instr_u wdata
);

    logic        last_en;
    logic [3:0]  cnt;
    logic [15:0] prog_buf;

    // Counters and write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            last_en <= 1'b0;
            cnt     <= '0;
            we      <= 1'b0;
            waddr   <= '0;
        end else begin
            last_en <= prog_en;
            if (we)
                waddr <= waddr + 1'b1;
            if (prog_en && !last_en) begin
                cnt   <= '0;
                waddr <= '0;
                we    <= 1'b0;
            end else if (prog_wr) begin
                cnt <= (cnt == 4'd8) ? 4'd0 : cnt + 4'd1;
                we  <= (cnt == 4'd2) || (cnt == 4'd4) || (cnt == 4'd6) || (cnt == 4'd8);
            end else begin
                we <= 1'b0;
            end
        end
    end

    // Nine bytes make four 18-bit words, low byte first
    always_ff @(posedge clk) begin
        if (prog_wr) begin
            prog_buf <= {prog_data, prog_buf[15:8]};
            case (cnt)
                4'd2:    wdata <= {prog_data[1:0], prog_buf};
                4'd4:    wdata <= {prog_data[3:0], prog_buf[15:2]};
                4'd6:    wdata <= {prog_data[5:0], prog_buf[15:4]};
                4'd8:    wdata <= {prog_data, prog_buf[15:6]};
                default: wdata <= wdata;
            endcase
        end
    end

endmodule

//--- verilog/cheat_irom.sv
// Cheat instruction RAM
`include "cheat_config.svh"

module cheat_irom (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`CHEAT_IAW-1:0]   waddr,
    input  cheat_pkg::cheat_instr_u wdata,
    input  logic [`CHEAT_IAW-1:0]   raddr,
    output cheat_pkg::cheat_instr_u rdata
);

    cheat_pkg::cheat_instr_u mem [0:(1 << `CHEAT_IAW)-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // Registered read, word ready one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- verilog/cheat_sequencer.sv
// Frame-started cheat sequencer
`include "cheat_config.svh"

module cheat_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lvbl,
    input  logic                    enable,
    output logic [`CHEAT_IAW-1:0]   iaddr,
    input  cheat_pkg::cheat_instr_u idata,
    sdram_if.requester              bank
);

    localparam int WDOG_W = $clog2(`CHEAT_WDOG_FRAMES + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_EXEC  = 2'd2;
    localparam logic [1:0] ST_BUS   = 2'd3;

    logic [1:0]        state;
    cheat_pkg::iaddr_t pc;
    logic              lvbl_last;
    logic              blank_fall;
    logic [WDOG_W-1:0] wdog;
    logic              wdog_hit;
    logic              req_rd;
    logic              req_wr;
    logic              taken;
    logic [7:0]        regs [0:7];
    logic [23:0]       addr_full;

    assign blank_fall = lvbl_last & ~lvbl;
    assign wdog_hit   = (wdog == WDOG_W'(`CHEAT_WDOG_FRAMES));
    assign iaddr      = pc;

    // Bank request composed from the byte registers
    assign addr_full  = {regs[cheat_pkg::ADDR2], regs[cheat_pkg::ADDR1], regs[cheat_pkg::ADDR0]};
    assign bank.addr  = addr_full[`CHEAT_AW-1:0];
    assign bank.din   = {regs[cheat_pkg::DATA_HI], regs[cheat_pkg::DATA_LO]};
    assign bank.din_m = regs[cheat_pkg::MASK][1:0];
    assign bank.rd    = req_rd;
    assign bank.wr    = req_wr;

    // Branch condition against the last read word
    always_comb begin
        case (idata.jmp.cond)
            cheat_pkg::EQ: taken = (bank.din == {regs[cheat_pkg::RDATA_HI], regs[cheat_pkg::RDATA_LO]});
            cheat_pkg::NE: taken = (bank.din != {regs[cheat_pkg::RDATA_HI], regs[cheat_pkg::RDATA_LO]});
            default:       taken = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            pc        <= '0;
            lvbl_last <= 1'b0;
            wdog      <= '0;
            req_rd    <= 1'b0;
            req_wr    <= 1'b0;
        end else begin
            lvbl_last <= lvbl;
            if (blank_fall && state != ST_IDLE && !wdog_hit)
                wdog <= wdog + 1'b1;
            case (state)
                ST_IDLE: begin
                    if (blank_fall && enable) begin
                        pc    <= '0;
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= wdog_hit ? ST_IDLE : ST_EXEC;
                end
                ST_EXEC: begin
                    state <= ST_FETCH;
                    pc    <= pc + 1'b1;
                    case (idata.imm.op)
                        cheat_pkg::WR: begin
                            req_wr <= 1'b1;
                            pc     <= pc;
                            state  <= ST_BUS;
                        end
                        cheat_pkg::RD: begin
                            req_rd <= 1'b1;
                            pc     <= pc;
                            state  <= ST_BUS;
                        end
                        cheat_pkg::JMP: begin
                            if (taken)
                                pc <= idata.jmp.target[`CHEAT_IAW-1:0];
                        end
                        cheat_pkg::END: begin
                            state <= ST_IDLE;
                            wdog  <= '0;
                        end
                        default: ;
                    endcase
                end
                default: begin
                    // Hold the access until the bank finishes
                    if (bank.rdy) begin
                        req_rd <= 1'b0;
                        req_wr <= 1'b0;
                        pc     <= pc + 1'b1;
                        state  <= ST_FETCH;
                    end
                end
            endcase
            // Runaway program goes back to the start
            if (wdog_hit && state == ST_FETCH) begin
                pc   <= '0;
                wdog <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXEC && idata.imm.op == cheat_pkg::LDI)
            regs[idata.imm.rd] <= idata.imm.imm;
        if (bank.dst && req_rd)
            {regs[cheat_pkg::RDATA_HI], regs[cheat_pkg::RDATA_LO]} <= bank.dout;
    end

endmodule

//--- verilog/sdram_arbiter.sv
// Game and cheat bank arbiter
`include "cheat_config.svh"

module sdram_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`CHEAT_AW-1:0] game_addr,
    input  logic                 game_rd,
    input  logic                 game_wr,
    input  logic [15:0]          game_din,
    input  logic [1:0]           game_din_m,
    output logic                 game_dst,
    output logic                 game_rdy,
    sdram_if.arbiter             cheat,
    output logic [`CHEAT_AW-1:0] ba0_addr,
    output logic                 ba0_rd,
    output logic                 ba0_wr,
    output logic [15:0]          ba0_din,
    output logic [1:0]           ba0_din_m,
    input  logic                 ba0_dst,
    input  logic                 ba0_rdy,
    input  logic [15:0]          data_read
);

    logic busy;
    logic owner;    // 1 when the sequencer holds the bank

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (busy) begin
            if (ba0_rdy)
                busy <= 1'b0;
        end else if (game_rd || game_wr) begin
            busy  <= 1'b1;
            owner <= 1'b0;
        end else if (cheat.rd || cheat.wr) begin
            busy  <= 1'b1;
            owner <= 1'b1;
        end
    end

    // Bank sees strobes only after the grant
    assign ba0_addr  = owner ? cheat.addr  : game_addr;
    assign ba0_rd    = busy & (owner ? cheat.rd : game_rd);
    assign ba0_wr    = busy & (owner ? cheat.wr : game_wr);
    assign ba0_din   = owner ? cheat.din   : game_din;
    assign ba0_din_m = owner ? cheat.din_m : game_din_m;

    assign game_dst   = busy & ~owner & ba0_dst;
    assign game_rdy   = busy & ~owner & ba0_rdy;
    assign cheat.dst  = busy &  owner & ba0_dst;
    assign cheat.rdy  = busy &  owner & ba0_rdy;
    assign cheat.dout = owner ? data_read : 16'd0;

endmodule

//--- verilog/cheat_engine.sv
// Cheat engine top level
`include "cheat_config.svh"

module cheat_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lvbl,
    input  logic                 enable,
    input  logic                 prog_en,
    input  logic                 prog_wr,
    input  logic [7:0]           prog_data,
    input  logic [`CHEAT_AW-1:0] game_addr,
    input  logic                 game_rd,
    input  logic                 game_wr,
    input  logic [15:0]          game_din,
    input  logic [1:0]           game_din_m,
    output logic                 game_dst,
    output logic                 game_rdy,
    output logic [`CHEAT_AW-1:0] ba0_addr,
    output logic                 ba0_rd,
    output logic                 ba0_wr,
    output logic [15:0]          ba0_din,
    output logic [1:0]           ba0_din_m,
    input  logic                 ba0_dst,
    input  logic                 ba0_rdy,
    input  logic [15:0]          data_read
);

    logic                    irom_we;
    logic [`CHEAT_IAW-1:0]   irom_waddr;
    cheat_pkg::cheat_instr_u irom_wdata;
    logic [`CHEAT_IAW-1:0]   iaddr;
    cheat_pkg::cheat_instr_u idata;

    // Sequencer side of the bank
    sdram_if cheat_bus ();

    cheat_loader u_loader (
        .clk       (clk),
        .rst       (rst),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .we        (irom_we),
        .waddr     (irom_waddr),
        .wdata     (irom_wdata)
    );

    cheat_irom u_irom (
        .clk   (clk),
        .we    (irom_we),
        .waddr (irom_waddr),
        .wdata (irom_wdata),
        .raddr (iaddr),
        .rdata (idata)
    );

    cheat_sequencer u_seq (
        .clk    (clk),
        .rst    (rst),
        .lvbl   (lvbl),
        .enable (enable),
        .iaddr  (iaddr),
        .idata  (idata),
        .bank   (cheat_bus.requester)
    );

    sdram_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .game_addr  (game_addr),
        .game_rd    (game_rd),
        .game_wr    (game_wr),
        .game_din   (game_din),
        .game_din_m (game_din_m),
        .game_dst   (game_dst),
        .game_rdy   (game_rdy),
        .cheat      (cheat_bus.arbiter),
        .ba0_addr   (ba0_addr),
        .ba0_rd     (ba0_rd),
        .ba0_wr     (ba0_wr),
        .ba0_din    (ba0_din),
        .ba0_din_m  (ba0_din_m),
        .ba0_dst    (ba0_dst),
        .ba0_rdy    (ba0_rdy),
        .data_read  (data_read)
    );

endmodule

//--- verification/cheat_engine_sva.sv
// Arbiter protocol assertions
`include "cheat_config.svh"

module cheat_engine_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 ba0_rd,
    input logic                 ba0_wr,
    input logic                 game_rd,
    input logic                 game_wr,
    input logic                 game_rdy,
    input logic                 cheat_rd,
    input logic                 cheat_wr,
    input logic                 cheat_rdy,
    input logic [`CHEAT_AW-1:0] cheat_addr,
    input logic [15:0]          cheat_din
);

    // One access type at a time on the bank
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(ba0_rd && ba0_wr))
        else $error("bank read and write strobes high together");

    // Game ready only ends an access that the game itself placed on the bank
    a_game_rdy_owner: assert property (@(posedge clk) disable iff (rst)
        game_rdy |-> (game_rd || game_wr) && (ba0_rd == game_rd) && (ba0_wr == game_wr))
        else $error("game ready while the sequencer owns the bank");

    a_cheat_rdy_owner: assert property (@(posedge clk) disable iff (rst)
        cheat_rdy |-> (cheat_rd || cheat_wr))
        else $error("sequencer ready without a pending sequencer request");

    // Sequencer request held unchanged until ready
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (cheat_rd || cheat_wr) && !cheat_rdy |=>
            $stable(cheat_rd) && $stable(cheat_wr) && $stable(cheat_addr) && $stable(cheat_din))
        else $error("sequencer request changed before ready");

endmodule

bind sdram_arbiter cheat_engine_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .ba0_rd     (ba0_rd),
    .ba0_wr     (ba0_wr),
    .game_rd    (game_rd),
    .game_wr    (game_wr),
    .game_rdy   (game_rdy),
    .cheat_rd   (cheat.rd),
    .cheat_wr   (cheat.wr),
    .cheat_rdy  (cheat.rdy),
    .cheat_addr (cheat.addr),
    .cheat_din  (cheat.din)
);

//--- verification/cheat_engine_tb.sv
// Cheat engine testbench
`include "cheat_config.svh"

module cheat_engine_tb;

    localparam int NSCEN = 6;

    logic                 clk;
    logic                 rst;
    logic                 lvbl;
    logic                 enable;
    logic                 prog_en;
    logic                 prog_wr;
    logic [7:0]           prog_data;
    logic [`CHEAT_AW-1:0] game_addr;
    logic                 game_rd;
    logic                 game_wr;
    logic [15:0]          game_din;
    logic [1:0]           game_din_m;
    logic                 game_dst;
    logic                 game_rdy;
    logic [`CHEAT_AW-1:0] ba0_addr;
    logic                 ba0_rd;
    logic                 ba0_wr;
    logic [15:0]          ba0_din;
    logic [1:0]           ba0_din_m;
    logic                 ba0_dst;
    logic                 ba0_rdy;
    logic [15:0]          data_read;

    // SDRAM model state
    logic [15:0] mem [0:65535];
    integer      seed;
    int          lat;
    int          n_wr;
    int          n_acc;

    int errors;
    int checks;

    // Scenario table
    string       names    [0:NSCEN-1];
    int          kind     [0:NSCEN-1];
    bit          en_tab   [0:NSCEN-1];
    bit          game_tab [0:NSCEN-1];
    logic [15:0] pre_a    [0:NSCEN-1][0:1];
    logic [15:0] pre_d    [0:NSCEN-1][0:1];
    logic [15:0] exp_a    [0:NSCEN-1][0:1];
    logic [15:0] exp_d    [0:NSCEN-1][0:1];
    int          exp_wr   [0:NSCEN-1];
    int          exp_acc  [0:NSCEN-1];

    cheat_engine uut (
        .clk(clk), .rst(rst), .lvbl(lvbl), .enable(enable),
        .prog_en(prog_en), .prog_wr(prog_wr), .prog_data(prog_data),
        .game_addr(game_addr), .game_rd(game_rd), .game_wr(game_wr),
        .game_din(game_din), .game_din_m(game_din_m),
        .game_dst(game_dst), .game_rdy(game_rdy),
        .ba0_addr(ba0_addr), .ba0_rd(ba0_rd), .ba0_wr(ba0_wr),
        .ba0_din(ba0_din), .ba0_din_m(ba0_din_m),
        .ba0_dst(ba0_dst), .ba0_rdy(ba0_rdy), .data_read(data_read)
    );

    always #50 clk = ~clk;

    // Bank model, 1 to 4 cycles per access, dst and rdy together
    always @(posedge clk) begin
        ba0_dst <= 1'b0;
        ba0_rdy <= 1'b0;
        if (rst) begin
            lat <= 0;
        end else if (lat != 0) begin
            lat <= lat - 1;
            if (lat == 1) begin
                if (ba0_wr) begin
                    mem[ba0_addr[15:0]] <= {
                        ba0_din_m[1] ? mem[ba0_addr[15:0]][15:8] : ba0_din[15:8],
                        ba0_din_m[0] ? mem[ba0_addr[15:0]][7:0]  : ba0_din[7:0]};
                    n_wr <= n_wr + 1;
                end else begin
                    data_read <= mem[ba0_addr[15:0]];
                end
                n_acc   <= n_acc + 1;
                ba0_dst <= 1'b1;
                ba0_rdy <= 1'b1;
            end
        end else if ((ba0_rd || ba0_wr) && !ba0_rdy) begin
            lat <= 1 + ($random(seed) & 3);
        end
    end

    function automatic logic [17:0] ldi(input logic [2:0] r, input logic [7:0] imm);
        return {4'(cheat_pkg::LDI), 3'b000, r, imm};
    endfunction

    function automatic logic [17:0] bare(input cheat_pkg::cheat_op_e op);
        return {4'(op), 14'd0};
    endfunction

    // Kind 0 writes abcd to 1234, kind 1 reads 0300 and skips the write on EQ
    function automatic logic [17:0] program_word(input int k, input int i);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] dlo;
        logic [7:0] dhi;
        a0  = (k == 0) ? 8'h34 : 8'h00;
        a1  = (k == 0) ? 8'h12 : 8'h03;
        dlo = (k == 0) ? 8'hcd : 8'h22;
        dhi = (k == 0) ? 8'hab : 8'h11;
        case (i)
            0: return ldi(3'd0, a0);
            1: return ldi(3'd1, a1);
            2: return ldi(3'd2, 8'h00);
            3: return ldi(3'd3, dlo);
            4: return ldi(3'd4, dhi);
            5: return ldi(3'd5, 8'h00);
            6: return (k == 0) ? bare(cheat_pkg::WR) : bare(cheat_pkg::RD);
            7: return (k == 0) ? bare(cheat_pkg::END)
                               : {4'(cheat_pkg::JMP), 2'(cheat_pkg::EQ), 12'd10};
            8: return (k == 0) ? 18'd0 : ldi(3'd0, 8'h01);
            9: return (k == 0) ? 18'd0 : bare(cheat_pkg::WR);
            10: return (k == 0) ? 18'd0 : bare(cheat_pkg::END);
            default: return 18'd0;
        endcase
    endfunction

    task automatic add_row(input int i, input string nm, input int k, input bit en,
                           input bit gm, input logic [15:0] pa0, input logic [15:0] pd0,
                           input logic [15:0] pa1, input logic [15:0] pd1,
                           input logic [15:0] ed0, input logic [15:0] ed1,
                           input int wr, input int acc);
        names[i]    = nm;
        kind[i]     = k;
        en_tab[i]   = en;
        game_tab[i] = gm;
        pre_a[i][0] = pa0;
        pre_d[i][0] = pd0;
        pre_a[i][1] = pa1;
        pre_d[i][1] = pd1;
        exp_a[i][0] = pa0;
        exp_d[i][0] = ed0;
        exp_a[i][1] = pa1;
        exp_d[i][1] = ed1;
        exp_wr[i]   = wr;
        exp_acc[i]  = acc;
    endtask

    // Nine bytes per four words, low byte first
    task automatic load_program(input int k);
        logic [71:0] group;
        int          nw;
        nw = (k == 0) ? 8 : 12;
        @(posedge clk);
        prog_en <= 1'b1;
        @(posedge clk);
        for (int g = 0; g < nw / 4; g++) begin
            group = {program_word(k, 4*g+3), program_word(k, 4*g+2),
                     program_word(k, 4*g+1), program_word(k, 4*g)};
            for (int b = 0; b < 9; b++) begin
                prog_wr   <= 1'b1;
                prog_data <= group[8*b +: 8];
                @(posedge clk);
            end
        end
        prog_wr <= 1'b0;
        repeat (2) @(posedge clk);
        prog_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic game_access(input string nm, input bit is_wr, input logic [15:0] addr,
                               input logic [15:0] data);
        int          t;
        bit          done;
        logic [15:0] rdata;
        t     = 0;
        done  = 1'b0;
        rdata = 16'hxxxx;
        @(posedge clk);
        game_addr  <= `CHEAT_AW'(addr);
        game_din   <= data;
        game_din_m <= 2'b00;
        game_wr    <= is_wr;
        game_rd    <= !is_wr;
        while (!done && t < 200) begin
            @(posedge clk);
            t++;
            if (game_dst)
                rdata = data_read;
            if (game_rdy)
                done = 1'b1;
        end
        game_rd <= 1'b0;
        game_wr <= 1'b0;
        if (!done) begin
            $display("Timeout in %s: game access to %h never got ready", nm, addr);
            errors++;
        end else if (!is_wr) begin
            checks++;
            if (rdata !== data) begin
                $display("ERROR %s game read %h: expected %h actual %h", nm, addr, data, rdata);
                errors++;
            end
        end
    endtask

    // Two frames, game traffic starts just after the first blanking fall
    task automatic run_frames(input int s);
        for (int f = 0; f < 2; f++) begin
            @(posedge clk);
            lvbl <= 1'b1;
            repeat (20) @(posedge clk);
            lvbl <= 1'b0;
            repeat (3) @(posedge clk);
            if (game_tab[s] && f == 0) begin
                game_access(names[s], 1'b1, 16'h0200, 16'h5a5a);
                game_access(names[s], 1'b0, 16'h0200, 16'h5a5a);
            end
            repeat (150) @(posedge clk);
        end
    endtask

    task automatic check_scenario(input int s);
        for (int j = 0; j < 2; j++) begin
            checks++;
            if (mem[exp_a[s][j]] !== exp_d[s][j]) begin
                $display("ERROR %s mem[%h]: expected %h actual %h",
                         names[s], exp_a[s][j], exp_d[s][j], mem[exp_a[s][j]]);
                errors++;
            end
        end
        checks++;
        if (n_wr != exp_wr[s]) begin
            $display("ERROR %s write count: expected %0d actual %0d", names[s], exp_wr[s], n_wr);
            errors++;
        end
        checks++;
        if (n_acc != exp_acc[s]) begin
            $display("ERROR %s access count: expected %0d actual %0d",
                     names[s], exp_acc[s], n_acc);
            errors++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        lvbl       = 1'b1;
        enable     = 1'b0;
        prog_en    = 1'b0;
        prog_wr    = 1'b0;
        prog_data  = 8'd0;
        game_addr  = '0;
        game_rd    = 1'b0;
        game_wr    = 1'b0;
        game_din   = 16'd0;
        game_din_m = 2'd0;
        ba0_dst    = 1'b0;
        ba0_rdy    = 1'b0;
        data_read  = 16'd0;
        seed       = 32'ha2b5_fb97;
        errors     = 0;
        checks     = 0;

        add_row(0, "load_wr",    0, 1, 0, 16'h1234, 16'h0000, 16'h0300, 16'h0000,
                16'habcd, 16'h0000, 2, 2);
        add_row(1, "game_pass",  0, 0, 1, 16'h1234, 16'h1111, 16'h0200, 16'h0000,
                16'h1111, 16'h5a5a, 1, 2);
        add_row(2, "branch_eq",  1, 1, 0, 16'h0300, 16'h1122, 16'h0301, 16'h0000,
                16'h1122, 16'h0000, 0, 2);
        add_row(3, "branch_ne",  1, 1, 0, 16'h0300, 16'h3344, 16'h0301, 16'h0000,
                16'h3344, 16'h1122, 2, 4);
        add_row(4, "enable_off", 0, 0, 0, 16'h1234, 16'h0000, 16'h0300, 16'h0000,
                16'h0000, 16'h0000, 0, 0);
        add_row(5, "contention", 0, 1, 1, 16'h1234, 16'h0000, 16'h0200, 16'h0000,
                16'habcd, 16'h5a5a, 3, 4);

        for (int s = 0; s < NSCEN; s++) begin
            @(posedge clk);
            rst    <= 1'b1;
            enable <= en_tab[s];
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < 65536; i++)
                mem[i] = 16'(i) ^ 16'hc3a5;
            mem[pre_a[s][0]] = pre_d[s][0];
            mem[pre_a[s][1]] = pre_d[s][1];
            n_wr  = 0;
            n_acc = 0;
            load_program(kind[s]);
            run_frames(s);
            check_scenario(s);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- cheat_engine.f
+incdir+include
verilog/cheat_pkg.sv
verilog/sdram_if.sv
verilog/cheat_loader.sv
verilog/cheat_irom.sv
verilog/cheat_sequencer.sv
verilog/sdram_arbiter.sv
verilog/cheat_engine.sv
verification/cheat_engine_sva.sv
verification/cheat_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cheat engine simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f cheat_engine.f \
    --top-module cheat_engine_tb -Mdir obj_dir -o sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1 ; cat sim.log

grep -q '\*\*\* PASSED \*\*\*' sim.log && exit 0 || exit 1
